// ==== rv32_backend.f ====
hdl/rv32i_pkg.sv
hdl/exec_stage.sv
hdl/mem_stage.sv
hdl/lsu_axil_master.sv
hdl/data_ram_axil.sv
hdl/rv32_backend.sv
bench/rv32_backend_properties.sv
bench/rv32_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv32_backend testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f rv32_backend.f --top-module rv32_backend_tb -o vsim_tb
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

out=$(./obj_dir/vsim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
exit 1

// ==== bench/rv32_backend_tb.sv ====
module rv32_backend_tb
   import rv32i_pkg::*;
();

   typedef struct {
      issue_t    iss;
      logic      we;
      rv32i_word data;
      logic      redir;
      rv32i_word target;
      logic      is_mem;
   } entry_t;

   logic      clk_i;
   logic      rst_n_i;
   issue_t    issue_i;
   logic      issue_ready_o;
   wb_t       wb_o;
   redirect_t redirect_o;

   entry_t    tbl[$];
   int        exp_idx_q[$];
   int        exp_cyc_q[$];
   logic [7:0] mem_model [1024];
   rv32i_word rand_state;
   int        cycle;
   int        errors;
   int        checks;
   int        tests;
   int        busy_cycles;
   logic      tbl_built;
   logic      running;
   alu_op_e   ops [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                           alu_xor, alu_srl, alu_sra, alu_or, alu_and};
   cmp_op_e   cmps [6] = '{beq, bne, blt, bge, bltu, bgeu};

   rv32_backend dut_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .issue_i       (issue_i),
      .issue_ready_o (issue_ready_o),
      .wb_o          (wb_o),
      .redirect_o    (redirect_o)
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) cycle <= cycle + 1;

   function automatic rv32i_word next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   // two's complement order, decided by the sign bits first.
   function automatic logic signed_lt(rv32i_word a, rv32i_word b);
      if (a[31] != b[31]) return a[31];
      return a < b;
   endfunction

   function automatic rv32i_word alu_ref(alu_op_e op, rv32i_word a, rv32i_word b);
      case (op)
         alu_add:  return a + b;
         alu_sub:  return a - b;
         alu_sll:  return a << b[4:0];
         alu_slt:  return {31'b0, signed_lt(a, b)};
         alu_sltu: return (a < b) ? 32'd1 : 32'd0;
         alu_xor:  return a ^ b;
         alu_srl:  return a >> b[4:0];
         alu_sra:  return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffffffff >> b[4:0]));
         alu_or:   return a | b;
         default:  return a & b;
      endcase
   endfunction

   function automatic logic cmp_ref(cmp_op_e op, rv32i_word a, rv32i_word b);
      case (op)
         beq:     return a == b;
         bne:     return a != b;
         blt:     return signed_lt(a, b);
         bge:     return !signed_lt(a, b);
         bltu:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic ctrl_word_t make_ctrl(opcode_e opc, alu_op_e aop, cmp_op_e cop,
                                            mem_size_e sz, logic bimm, logic rd_en,
                                            logic wr_en, logic we);
      ctrl_word_t c;
      c.opcode     = opc;
      c.alu_op     = aop;
      c.cmp_op     = cop;
      c.mem_size   = sz;
      c.alu_b_imm  = bimm;
      c.marmux_sel = 1'b1;
      c.mem_read   = rd_en;
      c.mem_write  = wr_en;
      c.reg_we     = we;
      return c;
   endfunction

   task automatic push_entry(ctrl_word_t c, rv32i_word a, rv32i_word b, rv32i_word imm,
                             logic we, rv32i_word data, logic redir, rv32i_word target);
      entry_t e;
      e.iss.valid   = 1'b1;
      e.iss.ctrl    = c;
      e.iss.pc      = 32'h1000 + 32'(tbl.size() * 4);
      e.iss.rs1_val = a;
      e.iss.rs2_val = b;
      e.iss.imm     = imm;
      e.iss.rd      = reg_idx_t'(tbl.size() % 31 + 1);
      e.we          = we;
      e.data        = data;
      e.redir       = redir;
      e.target      = target;
      e.is_mem      = c.mem_read | c.mem_write;
      tbl.push_back(e);
   endtask

   task automatic add_alu(alu_op_e op, logic use_imm);
      rv32i_word a;
      rv32i_word b;
      rv32i_word r;
      rv32i_word imm;
      a   = next_rand();
      b   = next_rand();
      r   = next_rand();
      imm = {{20{r[11]}}, r[11:0]};
      push_entry(make_ctrl(use_imm ? op_imm : op_reg, op, beq, mem_w, use_imm, 0, 0, 1),
                 a, b, imm, 1'b1, alu_ref(op, a, use_imm ? imm : b), 1'b0, '0);
   endtask

   task automatic add_store(mem_size_e sz, rv32i_word addr, rv32i_word data);
      int n;
      n = (sz == mem_b) ? 1 : (sz == mem_h) ? 2 : 4;
      for (int k = 0; k < n; k++) mem_model[(addr[9:0] + k) % 1024] = data[8*k +: 8];
      push_entry(make_ctrl(op_store, alu_add, beq, sz, 1, 0, 1, 0),
                 addr & ~32'hf, data, addr & 32'hf, 1'b0, '0, 1'b0, '0);
   endtask

   task automatic add_load(mem_size_e sz, rv32i_word addr);
      rv32i_word v;
      int        a;
      a = addr[9:0];
      v = {mem_model[a | 3], mem_model[a | 2], mem_model[a | 1], mem_model[a]};
      case (sz)
         mem_b:  v = {{24{mem_model[a][7]}}, mem_model[a]};
         mem_bu: v = {24'b0, mem_model[a]};
         mem_h:  v = {{16{mem_model[a + 1][7]}}, mem_model[a + 1], mem_model[a]};
         mem_hu: v = {16'b0, mem_model[a + 1], mem_model[a]};
         default: ;
      endcase
      push_entry(make_ctrl(op_load, alu_add, beq, sz, 1, 1, 0, 1),
                 addr & ~32'hf, '0, addr & 32'hf, 1'b1, v, 1'b0, '0);
   endtask

   task automatic check_eq(string what, rv32i_word got, rv32i_word exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // at each falling edge: match writebacks against the expected queue.
   always @(negedge clk_i) begin
      int idx;
      int acc;
      if (running) begin
         if (!issue_ready_o) busy_cycles++;
         if (wb_o.valid) begin
            if (exp_idx_q.size() == 0) begin
               errors++;
               $display("error at %0t: writeback arrived with nothing outstanding", $time);
            end else begin
               idx = exp_idx_q.pop_front();
               acc = exp_cyc_q.pop_front();
               check_eq($sformatf("entry %0d we", idx), 32'(wb_o.we), 32'(tbl[idx].we));
               if (tbl[idx].we) begin
                  check_eq($sformatf("entry %0d rd", idx), 32'(wb_o.rd), 32'(tbl[idx].iss.rd));
                  check_eq($sformatf("entry %0d data", idx), wb_o.data, tbl[idx].data);
               end
               check_eq($sformatf("entry %0d redirect", idx), 32'(redirect_o.valid),
                        32'(tbl[idx].redir));
               if (tbl[idx].redir) check_eq($sformatf("entry %0d target", idx),
                                            redirect_o.target, tbl[idx].target);
               if (!tbl[idx].is_mem) check_eq($sformatf("entry %0d latency", idx),
                                              32'(cycle), 32'(acc + 1));
            end
         end else if (redirect_o.valid) begin
            errors++;
            $display("error at %0t: redirect without a writeback", $time);
         end
      end
   end

   task automatic drain();
      @(negedge clk_i);
      issue_i.valid = 1'b0;
      while (exp_idx_q.size() != 0) @(negedge clk_i);
   endtask

   task automatic apply_range(string name, int lo, int hi);
      int start_err;
      start_err = errors;
      for (int i = lo; i < hi; i++) begin
         @(negedge clk_i);
         issue_i = tbl[i].iss;
         while (!issue_ready_o) @(negedge clk_i);
         exp_idx_q.push_back(i); // accepted at the coming rising edge.
         exp_cyc_q.push_back(cycle + 1);
         if (tbl[i].redir) drain();
      end
      drain();
      tests++;
      $display("test %-8s %0d entries, %0d errors", name, hi - lo, errors - start_err);
   endtask

   initial begin
      int b0;
      int b1;
      int b2;
      int b3;
      int b4;
      int busy_before;
      rv32i_word a;
      rv32i_word b;
      rv32i_word imm;
      logic      tk;
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      issue_i     = '0;
      cycle       = 0;
      errors      = 0;
      checks      = 0;
      tests       = 0;
      busy_cycles = 0;
      running     = 1'b0;
      tbl_built   = 1'b0;
      rand_state  = 32'd58742;
      for (int i = 0; i < 1024; i++) mem_model[i] = '0;

      for (int i = 0; i < 20; i++) add_alu(ops[i % 10], i >= 10);
      imm = next_rand() & 32'hfffff000;
      push_entry(make_ctrl(op_lui, alu_add, beq, mem_w, 1, 0, 0, 1), '0, '0, imm, 1, imm, 0, '0);
      push_entry(make_ctrl(op_auipc, alu_add, beq, mem_w, 1, 0, 0, 1), '0, '0, imm, 1,
                 32'h1000 + 32'(tbl.size() * 4) + imm, 0, '0);
      b0 = tbl.size();
      for (int i = 0; i < 12; i++) begin
         a   = next_rand();
         b   = (i % 2 == 0) ? a : next_rand();
         imm = (next_rand() & 32'h1fe) - 32'h100;
         tk  = cmp_ref(cmps[i / 2], a, b);
         push_entry(make_ctrl(op_br, alu_add, cmps[i / 2], mem_w, 1, 0, 0, 0), a, b, imm, 0, '0,
                    tk, 32'h1000 + 32'(tbl.size() * 4) + imm);
      end
      b1 = tbl.size();
      for (int i = 0; i < 4; i++) begin
         a   = next_rand();
         imm = (next_rand() & 32'hffe) - 32'h800;
         b   = 32'h1000 + 32'(tbl.size() * 4);
         if (i % 2 == 0)
            push_entry(make_ctrl(op_jal, alu_add, beq, mem_w, 1, 0, 0, 1), a, '0, imm, 1, b + 4,
                       1, b + imm);
         else
            push_entry(make_ctrl(op_jalr, alu_add, beq, mem_w, 1, 0, 0, 1), a, '0, imm + 1, 1,
                       b + 4, 1, (a + imm + 1) & ~32'h1);
      end
      b2 = tbl.size();
      add_store(mem_w, 32'h40, next_rand());
      add_store(mem_h, 32'h44, next_rand());
      add_store(mem_h, 32'h46, next_rand());
      for (int k = 0; k < 4; k++) add_store(mem_b, 32'h348 + k, next_rand() | 32'h80);
      add_load(mem_w, 32'h40);
      add_load(mem_h, 32'h44);
      add_load(mem_hu, 32'h46);
      add_load(mem_h, 32'h42);
      add_load(mem_hu, 32'h40);
      for (int k = 0; k < 4; k++) add_load((k % 2) ? mem_bu : mem_b, 32'h348 + k);
      add_load(mem_b, 32'h41);
      add_load(mem_bu, 32'h43);
      b3 = tbl.size();
      add_load(mem_w, 32'h44);
      add_alu(alu_add, 1);
      add_alu(alu_xor, 0);
      add_alu(alu_sra, 0);
      add_store(mem_w, 32'h1fc, next_rand());
      add_alu(alu_sub, 0);
      add_load(mem_hu, 32'h1fe);
      add_alu(alu_sltu, 1);
      b4 = tbl.size();
      tbl_built = 1'b1;

      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      running = 1'b1;
      for (int i = 0; i < 5; i++) begin
         @(negedge clk_i);
         check_eq("ready after reset", 32'(issue_ready_o), 32'd1);
         check_eq("wb valid idle", 32'(wb_o.valid), 32'd0);
         check_eq("redirect idle", 32'(redirect_o.valid), 32'd0);
      end
      tests++;
      $display("test %-8s %0d errors", "reset", errors);

      apply_range("alu", 0, b0);
      apply_range("branch", b0, b1);
      apply_range("jump", b1, b2);
      apply_range("memory", b2, b3);
      busy_before = busy_cycles;
      apply_range("mixed", b3, b4);
      check_eq("ready drops in mixed", 32'(busy_cycles > busy_before), 32'd1);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      int limit;
      wait (tbl_built);
      limit = (tbl.size() * 20 + 20) * 100;
      #(limit);
      $display("timeout: the run did not finish within %0d time units", limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule : rv32_backend_tb

// ==== bench/rv32_backend_properties.sv ====
module rv32_backend_properties
   import rv32i_pkg::*;
(
   input logic    clk_i,
   input logic    rst_n_i,
   input ex_mem_t ex_mem_i,
   input logic    lsu_busy_i,
   input logic    wb_valid_i,
   input logic    redirect_valid_i,
   input logic    awvalid_i,
   input logic    awready_i,
   input logic    wvalid_i,
   input logic    wready_i,
   input logic    bvalid_i,
   input logic    bready_i,
   input logic    arvalid_i,
   input logic    arready_i,
   input logic    rvalid_i,
   input logic    rready_i
);

   aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      awvalid_i && !awready_i |=> awvalid_i) else $error("awvalid dropped before awready");
   w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wvalid_i && !wready_i |=> wvalid_i) else $error("wvalid dropped before wready");
   b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bvalid_i && !bready_i |=> bvalid_i) else $error("bvalid dropped before bready");
   ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      arvalid_i && !arready_i |=> arvalid_i) else $error("arvalid dropped before arready");
   r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i && !rready_i |=> rvalid_i) else $error("rvalid dropped before rready");

   // a busy lsu must keep the ex/mem register from taking a new issue.
   no_issue_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      lsu_busy_i |=> $stable(ex_mem_i)) else $error("issue accepted while lsu busy");
   redirect_with_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      redirect_valid_i |-> wb_valid_i) else $error("redirect without writeback");
   wb_low_in_reset: assert property (@(posedge clk_i)
      !rst_n_i |-> !wb_valid_i) else $error("writeback valid during reset");

endmodule : rv32_backend_properties

bind rv32_backend rv32_backend_properties props_i (
   .clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .ex_mem_i         (ex_mem),
   .lsu_busy_i       (lsu_busy),
   .wb_valid_i       (wb_o.valid),
   .redirect_valid_i (redirect_o.valid),
   .awvalid_i        (awvalid),
   .awready_i        (awready),
   .wvalid_i         (wvalid),
   .wready_i         (wready),
   .bvalid_i         (bvalid),
   .bready_i         (bready),
   .arvalid_i        (arvalid),
   .arready_i        (arready),
   .rvalid_i         (rvalid),
   .rready_i         (rready)
);

// ==== hdl/rv32_backend.sv ====
module rv32_backend
   import rv32i_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  issue_t    issue_i,
   output logic      issue_ready_o,
   output wb_t       wb_o,
   output redirect_t redirect_o
);

   ex_mem_t   ex_mem;
   mem_req_t  mem_req;
   rv32i_word mem_rdata;
   logic      mem_done;
   logic      mem_stall;
   logic      lsu_busy;
   logic      stall;
   rv32i_word awaddr;
   rv32i_word wdata;
   rv32i_word araddr;
   rv32i_word rdata;
   strb_t     wstrb;
   axi_resp_t bresp;
   axi_resp_t rresp;
   logic      awvalid;
   logic      awready;
   logic      wvalid;
   logic      wready;
   logic      bvalid;
   logic      bready;
   logic      arvalid;
   logic      arready;
   logic      rvalid;
   logic      rready;

   assign stall         = mem_stall | lsu_busy;
   assign issue_ready_o = ~stall;

   exec_stage exec_stage_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .issue_i  (issue_i),
      .stall_i  (stall),
      .ex_mem_o (ex_mem)
   );

   mem_stage mem_stage_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .ex_mem_i    (ex_mem),
      .mem_req_o   (mem_req),
      .mem_done_i  (mem_done),
      .mem_rdata_i (mem_rdata),
      .stall_o     (mem_stall),
      .wb_o        (wb_o),
      .redirect_o  (redirect_o)
   );

   lsu_axil_master lsu_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .mem_req_i (mem_req),
      .done_o    (mem_done),
      .rdata_o   (mem_rdata),
      .busy_o    (lsu_busy),
      .awaddr_o  (awaddr),
      .awvalid_o (awvalid),
      .awready_i (awready),
      .wdata_o   (wdata),
      .wstrb_o   (wstrb),
      .wvalid_o  (wvalid),
      .wready_i  (wready),
      .bvalid_i  (bvalid),
      .bready_o  (bready),
      .bresp_i   (bresp),
      .araddr_o  (araddr),
      .arvalid_o (arvalid),
      .arready_i (arready),
      .rdata_i   (rdata),
      .rvalid_i  (rvalid),
      .rready_o  (rready),
      .rresp_i   (rresp)
   );

   data_ram_axil ram_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .awaddr_i  (awaddr),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wdata_i   (wdata),
      .wstrb_i   (wstrb),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .bresp_o   (bresp),
      .araddr_i  (araddr),
      .arvalid_i (arvalid),
      .arready_o (arready),
      .rdata_o   (rdata),
      .rvalid_o  (rvalid),
      .rready_i  (rready),
      .rresp_o   (rresp)
   );

endmodule : rv32_backend

// ==== hdl/data_ram_axil.sv ====
module data_ram_axil
   import rv32i_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  rv32i_word awaddr_i,
   input  logic      awvalid_i,
   output logic      awready_o,
   input  rv32i_word wdata_i,
   input  strb_t     wstrb_i,
   input  logic      wvalid_i,
   output logic      wready_o,
   output logic      bvalid_o,
   input  logic      bready_i,
   output axi_resp_t bresp_o,
   input  rv32i_word araddr_i,
   input  logic      arvalid_i,
   output logic      arready_o,
   output rv32i_word rdata_o,
   output logic      rvalid_o,
   input  logic      rready_i,
   output axi_resp_t rresp_o
);

   rv32i_word mem_q [RAM_WORDS];
   ram_idx_t  wr_idx;
   ram_idx_t  rd_idx;
   logic      wr_fire;
   logic      rd_fire;

   assign wr_idx  = awaddr_i[RAM_AW+1:2];
   assign rd_idx  = araddr_i[RAM_AW+1:2];
   assign wr_fire = awvalid_i & wvalid_i & ~bvalid_o; // aw and w taken together.
   assign rd_fire = arvalid_i & ~rvalid_o;

   assign awready_o = wr_fire;
   assign wready_o  = wr_fire;
   assign arready_o = rd_fire;
   assign bresp_o   = AXI_OKAY;
   assign rresp_o   = AXI_OKAY;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < RAM_WORDS; i++) mem_q[i] <= '0;
      end else if (wr_fire) begin
         for (int b = 0; b < XLEN/8; b++) begin
            if (wstrb_i[b]) mem_q[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         if (wr_fire) bvalid_o <= 1'b1;
         else if (bready_i) bvalid_o <= 1'b0;
         if (rd_fire) rvalid_o <= 1'b1;
         else if (rready_i) rvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_fire) rdata_o <= mem_q[rd_idx];
   end

endmodule : data_ram_axil

// ==== hdl/lsu_axil_master.sv ====
module lsu_axil_master
   import rv32i_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  mem_req_t  mem_req_i,
   output logic      done_o,
   output rv32i_word rdata_o,
   output logic      busy_o,
   output rv32i_word awaddr_o,
   output logic      awvalid_o,
   input  logic      awready_i,
   output rv32i_word wdata_o,
   output strb_t     wstrb_o,
   output logic      wvalid_o,
   input  logic      wready_i,
   input  logic      bvalid_i,
   output logic      bready_o,
   input  axi_resp_t bresp_i,
   output rv32i_word araddr_o,
   output logic      arvalid_o,
   input  logic      arready_i,
   input  rv32i_word rdata_i,
   input  logic      rvalid_i,
   output logic      rready_o,
   input  axi_resp_t rresp_i
);

   typedef enum logic [2:0] {
      s_idle,
      s_write,
      s_wait_b,
      s_read,
      s_wait_r,
      s_done
   } lsu_state_e;

   lsu_state_e state_q;
   logic       aw_pend_q;
   logic       w_pend_q;
   rv32i_word  addr_q;
   rv32i_word  wdata_q;
   strb_t      wstrb_q;
   rv32i_word  rdata_q;
   axi_resp_t  resp_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= s_idle;
         aw_pend_q <= 1'b0;
         w_pend_q  <= 1'b0;
      end else begin
         case (state_q)
            s_idle: begin
               if (mem_req_i.write) begin
                  state_q   <= s_write;
                  aw_pend_q <= 1'b1;
                  w_pend_q  <= 1'b1;
               end else if (mem_req_i.read) begin
                  state_q <= s_read;
               end
            end
            s_write: begin
               if (awready_i) aw_pend_q <= 1'b0;
               if (wready_i) w_pend_q <= 1'b0;
               if ((awready_i | ~aw_pend_q) & (wready_i | ~w_pend_q)) state_q <= s_wait_b;
            end
            s_wait_b: if (bvalid_i) state_q <= s_done;
            s_read:   if (arready_i) state_q <= s_wait_r;
            s_wait_r: if (rvalid_i) state_q <= s_done;
            default:  state_q <= s_idle; // done lasts one cycle.
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == s_idle) begin
         addr_q  <= mem_req_i.addr;
         wdata_q <= mem_req_i.wdata;
         wstrb_q <= mem_req_i.wstrb;
      end
      if (state_q == s_wait_b && bvalid_i) resp_q <= bresp_i;
      if (state_q == s_wait_r && rvalid_i) begin
         rdata_q <= rdata_i;
         resp_q  <= rresp_i;
      end
   end

   assign awaddr_o  = addr_q;
   assign araddr_o  = addr_q;
   assign wdata_o   = wdata_q;
   assign wstrb_o   = wstrb_q;
   assign awvalid_o = aw_pend_q;
   assign wvalid_o  = w_pend_q;
   assign arvalid_o = (state_q == s_read);
   assign bready_o  = (state_q == s_wait_b);
   assign rready_o  = (state_q == s_wait_r);
   assign done_o    = (state_q == s_done);
   assign busy_o    = (state_q != s_idle) && (state_q != s_done);
   assign rdata_o   = (resp_q == AXI_OKAY) ? rdata_q : '0; // error reads return zero.

endmodule : lsu_axil_master

// ==== hdl/mem_stage.sv ====
module mem_stage
   import rv32i_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  ex_mem_t   ex_mem_i,
   output mem_req_t  mem_req_o,
   input  logic      mem_done_i,
   input  rv32i_word mem_rdata_i,
   output logic      stall_o,
   output wb_t       wb_o,
   output redirect_t redirect_o
);

   rv32i_word  addr;
   logic [1:0] offset;
   logic       is_mem;
   logic       is_jump;
   logic       take;
   rv32i_word  byte_lane;
   rv32i_word  half_lane;
   rv32i_word  load_data;
   rv32i_word  wb_data;

   assign addr    = ex_mem_i.ctrl.marmux_sel ? ex_mem_i.alu_out : ex_mem_i.pc;
   assign offset  = addr[1:0];
   assign is_mem  = ex_mem_i.valid & (ex_mem_i.ctrl.mem_read | ex_mem_i.ctrl.mem_write);
   assign stall_o = is_mem & ~mem_done_i; // hold until the lsu finishes.

   always_comb begin
      mem_req_o.read  = ex_mem_i.valid & ex_mem_i.ctrl.mem_read;
      mem_req_o.write = ex_mem_i.valid & ex_mem_i.ctrl.mem_write;
      mem_req_o.addr  = {addr[XLEN-1:2], 2'b00};
      case (ex_mem_i.ctrl.mem_size)
         mem_b, mem_bu: begin
            mem_req_o.wstrb = 4'b0001 << offset;
            mem_req_o.wdata = ex_mem_i.rs2_val << {offset, 3'b000};
         end
         mem_h, mem_hu: begin
            mem_req_o.wstrb = 4'b0011 << {offset[1], 1'b0};
            mem_req_o.wdata = ex_mem_i.rs2_val << {offset[1], 4'b0000};
         end
         default: begin
            mem_req_o.wstrb = 4'b1111;
            mem_req_o.wdata = ex_mem_i.rs2_val;
         end
      endcase
   end

   assign byte_lane = mem_rdata_i >> {offset, 3'b000};
   assign half_lane = mem_rdata_i >> {offset[1], 4'b0000};

   always_comb begin
      case (ex_mem_i.ctrl.mem_size)
         mem_b:   load_data = {{24{byte_lane[7]}}, byte_lane[7:0]};
         mem_bu:  load_data = {24'b0, byte_lane[7:0]};
         mem_h:   load_data = {{16{half_lane[15]}}, half_lane[15:0]};
         mem_hu:  load_data = {16'b0, half_lane[15:0]};
         default: load_data = mem_rdata_i;
      endcase
   end

   assign is_jump = (ex_mem_i.ctrl.opcode == op_jal) | (ex_mem_i.ctrl.opcode == op_jalr);
   assign take    = ((ex_mem_i.ctrl.opcode == op_br) & ex_mem_i.br_en) | is_jump;

   always_comb begin
      case (ex_mem_i.ctrl.opcode)
         op_load:          wb_data = load_data;
         op_jal, op_jalr:  wb_data = ex_mem_i.pc_plus4; // link.
         default:          wb_data = ex_mem_i.alu_out;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wb_o       <= '0;
         redirect_o <= '0;
      end else if (stall_o) begin
         wb_o.valid       <= 1'b0; // payload holds.
         redirect_o.valid <= 1'b0;
      end else begin
         wb_o.valid        <= ex_mem_i.valid;
         wb_o.we           <= ex_mem_i.valid & ex_mem_i.ctrl.reg_we;
         wb_o.rd           <= ex_mem_i.rd;
         wb_o.data         <= wb_data;
         redirect_o.valid  <= ex_mem_i.valid & take;
         redirect_o.target <= ex_mem_i.alu_out;
      end
   end

endmodule : mem_stage

// ==== hdl/exec_stage.sv ====
module exec_stage
   import rv32i_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  issue_t  issue_i,
   input  logic    stall_i,
   output ex_mem_t ex_mem_o
);

   rv32i_word op_b;
   rv32i_word alu_res;
   rv32i_word pc_imm;
   rv32i_word jalr_sum;
   rv32i_word target;
   rv32i_word result;
   logic      br_en;

   assign op_b     = issue_i.ctrl.alu_b_imm ? issue_i.imm : issue_i.rs2_val;
   assign pc_imm   = issue_i.pc + issue_i.imm;
   assign jalr_sum = issue_i.rs1_val + issue_i.imm;

   always_comb begin
      case (issue_i.ctrl.alu_op)
         alu_add:  alu_res = issue_i.rs1_val + op_b;
         alu_sub:  alu_res = issue_i.rs1_val - op_b;
         alu_sll:  alu_res = issue_i.rs1_val << op_b[4:0];
         alu_slt:  alu_res = {{(XLEN-1){1'b0}}, $signed(issue_i.rs1_val) < $signed(op_b)};
         alu_sltu: alu_res = {{(XLEN-1){1'b0}}, issue_i.rs1_val < op_b};
         alu_xor:  alu_res = issue_i.rs1_val ^ op_b;
         alu_srl:  alu_res = issue_i.rs1_val >> op_b[4:0];
         alu_sra:  alu_res = $unsigned($signed(issue_i.rs1_val) >>> op_b[4:0]);
         alu_or:   alu_res = issue_i.rs1_val | op_b;
         alu_and:  alu_res = issue_i.rs1_val & op_b;
         default:  alu_res = issue_i.rs1_val + op_b;
      endcase
   end

   // compares the register operands, never the immediate.
   always_comb begin
      case (issue_i.ctrl.cmp_op)
         beq:     br_en = issue_i.rs1_val == issue_i.rs2_val;
         bne:     br_en = issue_i.rs1_val != issue_i.rs2_val;
         blt:     br_en = $signed(issue_i.rs1_val) < $signed(issue_i.rs2_val);
         bge:     br_en = $signed(issue_i.rs1_val) >= $signed(issue_i.rs2_val);
         bltu:    br_en = issue_i.rs1_val < issue_i.rs2_val;
         bgeu:    br_en = issue_i.rs1_val >= issue_i.rs2_val;
         default: br_en = 1'b0;
      endcase
   end

   assign target = (issue_i.ctrl.opcode == op_jalr) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_imm;

   always_comb begin
      case (issue_i.ctrl.opcode)
         op_lui:                 result = issue_i.imm;
         op_auipc:               result = pc_imm;
         op_br, op_jal, op_jalr: result = target; // link value rides in pc_plus4.
         default:                result = alu_res;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex_mem_o <= '0;
      end else if (!stall_i) begin
         ex_mem_o.valid    <= issue_i.valid;
         ex_mem_o.ctrl     <= issue_i.ctrl;
         ex_mem_o.pc       <= issue_i.pc;
         ex_mem_o.pc_plus4 <= issue_i.pc + 32'd4;
         ex_mem_o.alu_out  <= result;
         ex_mem_o.br_en    <= br_en;
         ex_mem_o.rs2_val  <= issue_i.rs2_val;
         ex_mem_o.rd       <= issue_i.rd;
      end
   end

endmodule : exec_stage

// ==== hdl/rv32i_pkg.sv ====
package rv32i_pkg;

   localparam int XLEN      = 32;
   localparam int RAM_WORDS = 256;
   localparam int RAM_AW    = $clog2(RAM_WORDS);

   typedef logic [XLEN-1:0]   rv32i_word;
   typedef logic [4:0]        reg_idx_t;
   typedef logic [XLEN/8-1:0] strb_t;     // one bit per byte lane.
   typedef logic [1:0]        axi_resp_t;
   typedef logic [RAM_AW-1:0] ram_idx_t;

   localparam axi_resp_t AXI_OKAY = 2'b00;

   typedef enum logic [6:0] {
      op_lui   = 7'b0110111,
      op_auipc = 7'b0010111,
      op_jal   = 7'b1101111,
      op_jalr  = 7'b1100111,
      op_br    = 7'b1100011,
      op_load  = 7'b0000011,
      op_store = 7'b0100011,
      op_imm   = 7'b0010011,
      op_reg   = 7'b0110011
   } opcode_e;

   // {funct7[5], funct3}.
   typedef enum logic [3:0] {
      alu_add  = 4'b0000,
      alu_sll  = 4'b0001,
      alu_slt  = 4'b0010,
      alu_sltu = 4'b0011,
      alu_xor  = 4'b0100,
      alu_srl  = 4'b0101,
      alu_or   = 4'b0110,
      alu_and  = 4'b0111,
      alu_sub  = 4'b1000,
      alu_sra  = 4'b1101
   } alu_op_e;

   typedef enum logic [2:0] {
      beq  = 3'b000,
      bne  = 3'b001,
      blt  = 3'b100,
      bge  = 3'b101,
      bltu = 3'b110,
      bgeu = 3'b111
   } cmp_op_e;

   typedef enum logic [2:0] {
      mem_b  = 3'b000,
      mem_h  = 3'b001,
      mem_w  = 3'b010,
      mem_bu = 3'b100,
      mem_hu = 3'b101
   } mem_size_e;

   typedef struct packed {
      opcode_e   opcode;
      alu_op_e   alu_op;
      cmp_op_e   cmp_op;
      mem_size_e mem_size;
      logic      alu_b_imm;
      logic      marmux_sel; // 1 selects alu_out as data address.
      logic      mem_read;
      logic      mem_write;
      logic      reg_we;
   } ctrl_word_t;

   typedef struct packed {
      logic       valid;
      ctrl_word_t ctrl;
      rv32i_word  pc;
      rv32i_word  rs1_val;
      rv32i_word  rs2_val;
      rv32i_word  imm;
      reg_idx_t   rd;
   } issue_t;

   typedef struct packed {
      logic       valid;
      ctrl_word_t ctrl;
      rv32i_word  pc;
      rv32i_word  pc_plus4;
      rv32i_word  alu_out;  // holds the target for branches and jumps.
      logic       br_en;
      rv32i_word  rs2_val;
      reg_idx_t   rd;
   } ex_mem_t;

   typedef struct packed {
      logic      read;
      logic      write;
      rv32i_word addr;
      rv32i_word wdata;
      strb_t     wstrb;
   } mem_req_t;

   typedef struct packed {
      logic      valid;
      logic      we;
      reg_idx_t  rd;
      rv32i_word data;
   } wb_t;

   typedef struct packed {
      logic      valid;
      rv32i_word target;
   } redirect_t;

endpackage : rv32i_pkg
